// File: hw/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath width
`define XLEN      32
// first fetch address out of reset
`define RESET_PC  32'h0000_0000

// base opcodes, rv32im only
`define OP_RTYPE  7'b0110011
`define OP_ITYPE  7'b0010011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_SYSTEM 7'b1110011

`endif

// File: hw/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

	// width types
	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`XLEN-1:0] addr_t;
	typedef logic [4:0]       reg_idx_t;
	// {instr[30], funct3}, branches remapped
	typedef logic [3:0]       alu_fn_t;
	typedef logic [3:0]       mem_op_t;
	// straight copy of funct3
	typedef logic [2:0]       muldiv_op_t;
	typedef logic [2:0]       fn_sel_t;
	typedef logic [1:0]       b_sel_t;
	typedef logic [1:0]       pc_sel_t;

	// result select
	localparam fn_sel_t FN_ALU    = 3'd0;
	localparam fn_sel_t FN_PC4    = 3'd1;
	localparam fn_sel_t FN_MULDIV = 3'd2;
	localparam fn_sel_t FN_IMM    = 3'd3;
	localparam fn_sel_t FN_AUIPC  = 3'd4;
	localparam fn_sel_t FN_LOAD   = 3'd5;
	localparam fn_sel_t FN_CSR    = 3'd6;

	// operand b source
	localparam b_sel_t B_SEL_REG   = 2'd0;
	localparam b_sel_t B_SEL_IMM   = 2'd1;
	localparam b_sel_t B_SEL_SHAMT = 2'd2;

	// next pc source
	localparam pc_sel_t PC_SEQ  = 2'd0;
	localparam pc_sel_t PC_JUMP = 2'd2;

	// alu codes that branches map onto
	localparam alu_fn_t ALU_SLT  = 4'b0010;
	localparam alu_fn_t ALU_SLTU = 4'b0011;
	localparam alu_fn_t ALU_SUB  = 4'b1000;
	localparam alu_fn_t ALU_BGE  = 4'b1001;
	localparam alu_fn_t ALU_BGEU = 4'b1010;

	// memory access codes, stores have bit 3 set
	localparam mem_op_t MEM_NONE = 4'd0;
	localparam mem_op_t MEM_LB   = 4'd1;
	localparam mem_op_t MEM_LH   = 4'd2;
	localparam mem_op_t MEM_LW   = 4'd3;
	localparam mem_op_t MEM_LBU  = 4'd4;
	localparam mem_op_t MEM_LHU  = 4'd5;
	localparam mem_op_t MEM_SW   = 4'd8;
	localparam mem_op_t MEM_SB   = 4'd14;
	localparam mem_op_t MEM_SH   = 4'd15;

	// funct7 of the m extension
	localparam logic [6:0] F7_MULDIV = 7'b0000001;

	// funct12 of the privileged system words
	localparam logic [11:0] F12_ECALL = 12'h000;
	localparam logic [11:0] F12_URET  = 12'h002;
	localparam logic [11:0] F12_SRET  = 12'h102;
	localparam logic [11:0] F12_MRET  = 12'h302;
	localparam logic [11:0] F12_WFI   = 12'h105;

	// decoded control bundle
	typedef struct packed {
		b_sel_t     b_sel;
		logic       we;
		logic       csr_we;
		fn_sel_t    fn;
		alu_fn_t    alu_fn;
		logic       j;
		logic       jr;
		logic       bneq;
		logic       btype;
		logic       lui;
		logic       auipc;
		mem_op_t    mem_op;
		muldiv_op_t muldiv_op;
		pc_sel_t    pcselect;
		logic       ecall;
		logic       uret;
		logic       sret;
		logic       mret;
		logic       wfi;
		logic       illegal_instr;
	} ctrl_t;

	// fetched word with its address
	typedef struct packed {
		addr_t pc;
		word_t instr;
	} fetch_t;

	// bundle handed to execute
	typedef struct packed {
		ctrl_t    ctrl;
		word_t    imm;
		addr_t    pc;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
	} dec_out_t;

endpackage

// File: hw/instr_decoder.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module instr_decoder (
	input  rv_pkg::word_t i_instr,
	output rv_pkg::ctrl_t o_ctrl
);

	// raw instruction fields
	logic [6:0]  op;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [11:0] funct12;
	logic        bit30;

	// class flags
	logic muldiv;
	logic shift_imm;
	logic nop;

	assign op      = i_instr[6:0];
	assign funct3  = i_instr[14:12];
	assign funct7  = i_instr[31:25];
	assign funct12 = i_instr[31:20];
	assign bit30   = i_instr[30];

	// m extension rides on the r-type opcode
	assign muldiv    = (funct7 == rv_pkg::F7_MULDIV);
	// slli, srli, srai
	assign shift_imm = (funct3 == 3'b001) || (funct3 == 3'b101);
	// all-zero word passes through as a bubble
	assign nop       = ~|i_instr;

	always_comb begin
		o_ctrl           = '0;
		o_ctrl.b_sel     = rv_pkg::B_SEL_REG;
		o_ctrl.fn        = rv_pkg::FN_ALU;
		o_ctrl.mem_op    = rv_pkg::MEM_NONE;
		o_ctrl.pcselect  = rv_pkg::PC_SEQ;

		case (op)
			`OP_RTYPE: begin
				o_ctrl.we = 1'b1;
				if (muldiv) begin
					o_ctrl.fn        = rv_pkg::FN_MULDIV;
					o_ctrl.muldiv_op = funct3;
				end else begin
					// bit30 picks sub and sra
					o_ctrl.alu_fn = {bit30, funct3};
				end
			end
			`OP_ITYPE: begin
				o_ctrl.we = 1'b1;
				if (shift_imm) begin
					// shamt in rs2 slot, bit30 still marks srai
					o_ctrl.b_sel  = rv_pkg::B_SEL_SHAMT;
					o_ctrl.alu_fn = {bit30, funct3};
				end else begin
					// bit30 belongs to the immediate here
					o_ctrl.b_sel  = rv_pkg::B_SEL_IMM;
					o_ctrl.alu_fn = {1'b0, funct3};
				end
			end
			`OP_LOAD: begin
				o_ctrl.we    = 1'b1;
				o_ctrl.fn    = rv_pkg::FN_LOAD;
				o_ctrl.b_sel = rv_pkg::B_SEL_IMM;
				case (funct3)
					3'b000:  o_ctrl.mem_op = rv_pkg::MEM_LB;
					3'b001:  o_ctrl.mem_op = rv_pkg::MEM_LH;
					3'b010:  o_ctrl.mem_op = rv_pkg::MEM_LW;
					3'b100:  o_ctrl.mem_op = rv_pkg::MEM_LBU;
					3'b101:  o_ctrl.mem_op = rv_pkg::MEM_LHU;
					default: o_ctrl.mem_op = rv_pkg::MEM_NONE;
				endcase
			end
			`OP_STORE: begin
				// address is rs1 + s-immediate, no writeback
				o_ctrl.b_sel = rv_pkg::B_SEL_IMM;
				case (funct3)
					3'b000:  o_ctrl.mem_op = rv_pkg::MEM_SB;
					3'b001:  o_ctrl.mem_op = rv_pkg::MEM_SH;
					3'b010:  o_ctrl.mem_op = rv_pkg::MEM_SW;
					default: o_ctrl.mem_op = rv_pkg::MEM_NONE;
				endcase
			end
			`OP_BRANCH: begin
				o_ctrl.btype    = 1'b1;
				o_ctrl.pcselect = rv_pkg::PC_JUMP;
				// execute inverts the zero test for bne
				o_ctrl.bneq     = (funct3 == 3'b001);
				// compare op for the alu
				case (funct3)
					3'b000,
					3'b001:  o_ctrl.alu_fn = rv_pkg::ALU_SUB;
					3'b100:  o_ctrl.alu_fn = rv_pkg::ALU_SLT;
					3'b101:  o_ctrl.alu_fn = rv_pkg::ALU_BGE;
					3'b110:  o_ctrl.alu_fn = rv_pkg::ALU_SLTU;
					3'b111:  o_ctrl.alu_fn = rv_pkg::ALU_BGEU;
					default: o_ctrl.alu_fn = '0;
				endcase
			end
			`OP_JAL: begin
				o_ctrl.we       = 1'b1;
				o_ctrl.j        = 1'b1;
				o_ctrl.fn       = rv_pkg::FN_PC4;
				o_ctrl.pcselect = rv_pkg::PC_JUMP;
			end
			`OP_JALR: begin
				// target rs1 + imm, link pc+4
				o_ctrl.we       = 1'b1;
				o_ctrl.jr       = 1'b1;
				o_ctrl.fn       = rv_pkg::FN_PC4;
				o_ctrl.b_sel    = rv_pkg::B_SEL_IMM;
				o_ctrl.pcselect = rv_pkg::PC_JUMP;
			end
			`OP_LUI: begin
				o_ctrl.we  = 1'b1;
				o_ctrl.lui = 1'b1;
				o_ctrl.fn  = rv_pkg::FN_IMM;
			end
			`OP_AUIPC: begin
				o_ctrl.we    = 1'b1;
				o_ctrl.auipc = 1'b1;
				o_ctrl.fn    = rv_pkg::FN_AUIPC;
			end
			`OP_SYSTEM: begin
				if (|funct3) begin
					// csrrw/s/c and immediate forms
					o_ctrl.we     = 1'b1;
					o_ctrl.csr_we = 1'b1;
					o_ctrl.fn     = rv_pkg::FN_CSR;
				end else begin
					// privileged words, told apart by funct12
					o_ctrl.ecall = (funct12 == rv_pkg::F12_ECALL);
					o_ctrl.uret  = (funct12 == rv_pkg::F12_URET);
					o_ctrl.sret  = (funct12 == rv_pkg::F12_SRET);
					o_ctrl.mret  = (funct12 == rv_pkg::F12_MRET);
					o_ctrl.wfi   = (funct12 == rv_pkg::F12_WFI);
				end
			end
			default: begin
				// unknown opcode, writes already cleared
				o_ctrl.illegal_instr = ~nop;
			end
		endcase
	end

endmodule

// File: hw/imm_gen.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module imm_gen (
	input  rv_pkg::word_t i_instr,
	output rv_pkg::word_t o_imm
);

	// sign bit is always instr[31]
	logic sign;

	assign sign = i_instr[31];

	always_comb begin
		case (i_instr[6:0])
			// i-format, csr address comes along for system
			`OP_ITYPE,
			`OP_LOAD,
			`OP_JALR,
			`OP_SYSTEM:
				o_imm = {{20{sign}}, i_instr[31:20]};
			// s-format
			`OP_STORE:
				o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
			// b-format, half-word aligned
			`OP_BRANCH:
				o_imm = {{19{sign}}, sign, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
			// u-format, upper 20 bits
			`OP_LUI,
			`OP_AUIPC:
				o_imm = {i_instr[31:12], 12'h000};
			// j-format
			`OP_JAL:
				o_imm = {{11{sign}}, sign, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
			// r-type and unknown words
			default:
				o_imm = '0;
		endcase
	end

endmodule

// File: hw/fetch_wb.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module fetch_wb (
	input  logic           i_clk,
	input  logic           i_reset,
	input  rv_pkg::word_t  i_wb_dat,
	input  logic           i_wb_ack,
	input  logic           i_ready,
	output logic           o_wb_cyc,
	output logic           o_wb_stb,
	output logic           o_wb_we,
	output rv_pkg::addr_t  o_wb_adr,
	output logic           o_valid,
	output rv_pkg::fetch_t o_fetch
);

	// idle only right after reset and then bus and hold alternate
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUS,
		ST_HOLD
	} fetch_state_t;

	fetch_state_t  state_q, state_d;
	rv_pkg::addr_t pc_q;
	rv_pkg::word_t instr_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: state_d = ST_BUS;
			// one read in flight until ack
			ST_BUS:  if (i_wb_ack) state_d = ST_HOLD;
			// next read starts right after the word is taken
			ST_HOLD: if (i_ready) state_d = ST_BUS;
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state_q <= ST_IDLE;
			pc_q    <= `RESET_PC;
		end else begin
			state_q <= state_d;
			// step only once the held word leaves
			if (state_q == ST_HOLD && i_ready)
				pc_q <= pc_q + 32'd4;
		end
	end

	// word buffer
	always_ff @(posedge i_clk) begin
		if (state_q == ST_BUS && i_wb_ack)
			instr_q <= i_wb_dat;
	end

	// read-only master addressing with the pc itself
	assign o_wb_cyc = (state_q == ST_BUS);
	assign o_wb_stb = (state_q == ST_BUS);
	assign o_wb_we  = 1'b0;
	assign o_wb_adr = pc_q;

	assign o_valid       = (state_q == ST_HOLD);
	assign o_fetch.pc    = pc_q;
	assign o_fetch.instr = instr_q;

	// stalled request keeps its address
	a_adr_stable: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_wb_stb && !i_wb_ack) |=> $stable(o_wb_adr));

	// cycle and strobe stay up until the slave acks
	a_cyc_until_ack: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_wb_cyc && !i_wb_ack) |=> (o_wb_cyc && o_wb_stb));

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic             i_clk,
	input  logic             i_reset,
	input  logic             i_valid,
	input  rv_pkg::fetch_t   i_fetch,
	input  logic             i_ready,
	output logic             o_ready,
	output logic             o_valid,
	output rv_pkg::dec_out_t o_dec
);

	rv_pkg::ctrl_t    ctrl;
	rv_pkg::word_t    imm;
	rv_pkg::dec_out_t dec_d;
	logic             valid_q;
	logic             take;

	instr_decoder i_instr_decoder (
		.i_instr (i_fetch.instr),
		.o_ctrl  (ctrl)
	);

	imm_gen i_imm_gen (
		.i_instr (i_fetch.instr),
		.o_imm   (imm)
	);

	// assemble the bundle, register fields taken raw
	always_comb begin
		dec_d.ctrl = ctrl;
		dec_d.imm  = imm;
		dec_d.pc   = i_fetch.pc;
		dec_d.rs1  = i_fetch.instr[19:15];
		dec_d.rs2  = i_fetch.instr[24:20];
		dec_d.rd   = i_fetch.instr[11:7];
	end

	// room when empty or when execute drains us this cycle
	assign o_ready = ~valid_q | i_ready;
	assign take    = i_valid & o_ready;

	always_ff @(posedge i_clk) begin
		if (i_reset)
			valid_q <= 1'b0;
		else if (o_ready)
			valid_q <= i_valid;
	end

	// payload register
	always_ff @(posedge i_clk) begin
		if (take)
			o_dec <= dec_d;
	end

	assign o_valid = valid_q;

	// stalled output holds
	a_out_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_valid && !i_ready) |=> (o_valid && $stable(o_dec)));

endmodule

// File: hw/frontend_top.sv
`timescale 1ns/1ps

module frontend_top (
	input  logic             i_clk,
	input  logic             i_reset,
	input  rv_pkg::word_t    i_wb_dat,
	input  logic             i_wb_ack,
	input  logic             i_ready,
	output logic             o_wb_cyc,
	output logic             o_wb_stb,
	output logic             o_wb_we,
	output rv_pkg::addr_t    o_wb_adr,
	output logic             o_valid,
	output rv_pkg::dec_out_t o_dec
);

	// fetch to decode handshake
	rv_pkg::fetch_t fetch;
	logic           fetch_valid;
	logic           dec_ready;

	fetch_wb i_fetch_wb (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_wb_dat (i_wb_dat),
		.i_wb_ack (i_wb_ack),
		.i_ready  (dec_ready),
		.o_wb_cyc (o_wb_cyc),
		.o_wb_stb (o_wb_stb),
		.o_wb_we  (o_wb_we),
		.o_wb_adr (o_wb_adr),
		.o_valid  (fetch_valid),
		.o_fetch  (fetch)
	);

	decode_stage i_decode_stage (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_valid (fetch_valid),
		.i_fetch (fetch),
		.i_ready (i_ready),
		.o_ready (dec_ready),
		.o_valid (o_valid),
		.o_dec   (o_dec)
	);

endmodule

// File: bench/decode_checker.sv
`timescale 1ns/1ps

module decode_checker #(
	parameter int N = 1
) (
	input  logic             i_clk,
	input  logic             i_reset,
	input  logic             i_valid,
	input  logic             i_ready,
	input  rv_pkg::dec_out_t i_dec,
	input  logic             i_wb_cyc,
	input  logic             i_wb_stb,
	input  logic             i_wb_we,
	input  logic [63:0]      i_exp_name,
	input  rv_pkg::word_t    i_exp_word,
	input  rv_pkg::word_t    i_exp_imm,
	input  rv_pkg::ctrl_t    i_exp_ctrl,
	output int               o_count,
	output int               o_errors
);

	// one field of one word with ctrl_t packed into 32 bits
	task automatic compare_field(input string field, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			o_errors = o_errors + 1;
			$display("FAILED %s %s: expected %h actual %h",
				i_exp_name, field, expected, actual);
		end
	endtask

	// single wishbone control line
	task automatic compare_bus(input string what, input logic expected,
		input logic actual);
		if (actual !== expected) begin
			o_errors = o_errors + 1;
			$display("FAILED wishbone %s: expected %b actual %b",
				what, expected, actual);
		end
	endtask

	// valid and ready settle well before the falling edge
	always @(negedge i_clk) begin
		if (i_reset) begin
			o_count  = 0;
			o_errors = 0;
		end else begin
			// read-only master with strobe inside the cycle
			compare_bus("we", 1'b0, i_wb_we);
			if (i_wb_stb !== 1'b0)
				compare_bus("cyc", 1'b1, i_wb_cyc);
			if (i_valid && i_ready && o_count < N) begin
				compare_field("ctrl", i_exp_ctrl, i_dec.ctrl);
				compare_field("imm", i_exp_imm, i_dec.imm);
				// word n sits at byte 4n when nothing is dropped
				compare_field("pc", 32'(o_count) << 2, i_dec.pc);
				// register indices at their fixed positions
				compare_field("rs1", {27'd0, i_exp_word[19:15]}, {27'd0, i_dec.rs1});
				compare_field("rs2", {27'd0, i_exp_word[24:20]}, {27'd0, i_dec.rs2});
				compare_field("rd", {27'd0, i_exp_word[11:7]}, {27'd0, i_dec.rd});
				o_count = o_count + 1;
			end
		end
	end

endmodule

// File: bench/tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend;

	localparam int NUM     = 26;
	// cycles allowed for each word
	localparam int TIMEOUT = 200;

	// name padded to eight characters
	typedef struct packed {
		logic [63:0]   name;
		rv_pkg::word_t word;
		rv_pkg::word_t imm;
		rv_pkg::ctrl_t ctrl;
	} row_t;

	row_t rows [NUM];
	row_t exp_row;

	logic             clk       = 1'b0;
	logic             rst;
	rv_pkg::word_t    wb_dat    = '0;
	logic             wb_ack    = 1'b0;
	logic             ready     = 1'b0;
	logic             wb_cyc;
	logic             wb_stb;
	logic             wb_we;
	rv_pkg::addr_t    wb_adr;
	logic             valid;
	rv_pkg::dec_out_t dec;

	// memory model state
	logic pending   = 1'b0;
	int   wait_left = 0;

	int seen;
	int mismatches;
	int timeouts;

	frontend_top i_frontend_top (
		.i_clk    (clk),
		.i_reset  (rst),
		.i_wb_dat (wb_dat),
		.i_wb_ack (wb_ack),
		.i_ready  (ready),
		.o_wb_cyc (wb_cyc),
		.o_wb_stb (wb_stb),
		.o_wb_we  (wb_we),
		.o_wb_adr (wb_adr),
		.o_valid  (valid),
		.o_dec    (dec)
	);

	decode_checker #(.N(NUM)) i_decode_checker (
		.i_clk      (clk),
		.i_reset    (rst),
		.i_valid    (valid),
		.i_ready    (ready),
		.i_dec      (dec),
		.i_wb_cyc   (wb_cyc),
		.i_wb_stb   (wb_stb),
		.i_wb_we    (wb_we),
		.i_exp_name (exp_row.name),
		.i_exp_word (exp_row.word),
		.i_exp_imm  (exp_row.imm),
		.i_exp_ctrl (exp_row.ctrl),
		.o_count    (seen),
		.o_errors   (mismatches)
	);

	// row the checker expects next
	assign exp_row = rows[(seen < NUM) ? seen : 0];

	always #20 clk = ~clk;

	task fill_table;
		// bit30 only counts for sub, sra and srai
		rows[0]  = '{"add     ", 32'h002081B3, 32'h0, '{we: 1'b1, default: '0}};
		rows[1]  = '{"sub     ", 32'h407302B3, 32'h0, '{we: 1'b1, alu_fn: 4'b1000, default: '0}};
		rows[2]  = '{"addi    ", 32'hFFB00093, 32'hFFFFFFFB,
			'{b_sel: 2'd1, we: 1'b1, default: '0}};
		rows[3]  = '{"slli    ", 32'h00309113, 32'h00000003,
			'{b_sel: 2'd2, we: 1'b1, alu_fn: 4'b0001, default: '0}};
		rows[4]  = '{"srai    ", 32'h40725213, 32'h00000407,
			'{b_sel: 2'd2, we: 1'b1, alu_fn: 4'b1101, default: '0}};
		rows[5]  = '{"xori    ", 32'h7FF2C313, 32'h000007FF,
			'{b_sel: 2'd1, we: 1'b1, alu_fn: 4'b0100, default: '0}};
		// loads and stores
		rows[6]  = '{"lw      ", 32'h00812383, 32'h00000008,
			'{b_sel: 2'd1, we: 1'b1, fn: 3'd5, mem_op: 4'd3, default: '0}};
		rows[7]  = '{"lbu     ", 32'hFFF1C403, 32'hFFFFFFFF,
			'{b_sel: 2'd1, we: 1'b1, fn: 3'd5, mem_op: 4'd4, default: '0}};
		rows[8]  = '{"sw      ", 32'h00512623, 32'h0000000C,
			'{b_sel: 2'd1, mem_op: 4'd8, default: '0}};
		rows[9]  = '{"sb      ", 32'hFE608E23, 32'hFFFFFFFC,
			'{b_sel: 2'd1, mem_op: 4'd14, default: '0}};
		rows[10] = '{"sh      ", 32'h00719323, 32'h00000006,
			'{b_sel: 2'd1, mem_op: 4'd15, default: '0}};
		// branches and jumps
		rows[11] = '{"beq     ", 32'h00208863, 32'h00000010,
			'{alu_fn: 4'b1000, btype: 1'b1, pcselect: 2'd2, default: '0}};
		rows[12] = '{"bne     ", 32'hFE419CE3, 32'hFFFFFFF8,
			'{alu_fn: 4'b1000, bneq: 1'b1, btype: 1'b1, pcselect: 2'd2, default: '0}};
		rows[13] = '{"bge     ", 32'h0062D263, 32'h00000004,
			'{alu_fn: 4'b1001, btype: 1'b1, pcselect: 2'd2, default: '0}};
		rows[14] = '{"jal     ", 32'h001000EF, 32'h00000800,
			'{we: 1'b1, fn: 3'd1, j: 1'b1, pcselect: 2'd2, default: '0}};
		rows[15] = '{"jalr    ", 32'h00008067, 32'h0,
			'{b_sel: 2'd1, we: 1'b1, fn: 3'd1, jr: 1'b1, pcselect: 2'd2, default: '0}};
		// upper immediates and m extension
		rows[16] = '{"lui     ", 32'h12345537, 32'h12345000,
			'{we: 1'b1, fn: 3'd3, lui: 1'b1, default: '0}};
		rows[17] = '{"auipc   ", 32'hFFFFF597, 32'hFFFFF000,
			'{we: 1'b1, fn: 3'd4, auipc: 1'b1, default: '0}};
		rows[18] = '{"divu    ", 32'h0220D7B3, 32'h0,
			'{we: 1'b1, fn: 3'd2, muldiv_op: 3'd5, default: '0}};
		// system words carry their funct12 as i immediate
		rows[19] = '{"ecall   ", 32'h00000073, 32'h0, '{ecall: 1'b1, default: '0}};
		rows[20] = '{"mret    ", 32'h30200073, 32'h00000302, '{mret: 1'b1, default: '0}};
		rows[21] = '{"wfi     ", 32'h10500073, 32'h00000105, '{wfi: 1'b1, default: '0}};
		rows[22] = '{"csrrw   ", 32'h300110F3, 32'h00000300,
			'{we: 1'b1, csr_we: 1'b1, fn: 3'd6, default: '0}};
		rows[23] = '{"csrrsi  ", 32'hF141E2F3, 32'hFFFFFF14,
			'{we: 1'b1, csr_we: 1'b1, fn: 3'd6, default: '0}};
		// opcode 7f is undefined and the zero word is a bubble
		rows[24] = '{"illegal ", 32'hFFFFFFFF, 32'h0, '{illegal_instr: 1'b1, default: '0}};
		rows[25] = '{"nop     ", 32'h00000000, 32'h0, '{default: '0}};
	endtask

	// table word at adr/4 or a pattern of the full address past the end
	function automatic rv_pkg::word_t fetch_word(input rv_pkg::addr_t adr);
		int idx;
		idx = int'(adr >> 2);
		if (idx < NUM)
			return rows[idx].word;
		return ~adr;
	endfunction

	// wishbone slave and execute back-pressure driven just after the edge
	always @(posedge clk) begin
		#2;
		ready = ($urandom_range(3, 0) != 0);
		if (wb_ack) begin
			// fetch took the word on this edge
			wb_ack  = 1'b0;
			pending = 1'b0;
		end else if (wb_stb && !pending) begin
			// new request with 0 to 3 wait states
			pending   = 1'b1;
			wait_left = $urandom_range(3, 0);
		end else if (pending && wait_left != 0) begin
			wait_left = wait_left - 1;
		end
		if (pending && wait_left == 0) begin
			wb_dat = fetch_word(wb_adr);
			wb_ack = 1'b1;
		end
	end

	// until word n has been taken by execute
	task automatic wait_for_word(input int n);
		int cycles;
		cycles = 0;
		while (seen <= n && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (seen <= n) begin
			timeouts++;
			$display("timeout: word %0d did not leave decode within %0d cycles", n, TIMEOUT);
		end
	endtask

	initial begin
		rst      = 1'b1;
		timeouts = 0;
		void'($urandom(79));
		fill_table();
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;
		// one table row per pass until the first stall
		for (int n = 0; n < NUM && timeouts == 0; n++) begin
			wait_for_word(n);
		end
		$display("words checked: %0d of %0d, mismatches: %0d, timeouts: %0d",
			seen, NUM, mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: compile.f
+incdir+hw
hw/rv_pkg.sv
hw/instr_decoder.sv
hw/imm_gen.sv
hw/fetch_wb.sv
hw/decode_stage.sv
hw/frontend_top.sv
bench/decode_checker.sv
bench/tb_frontend.sv

// File: run.sh
#!/bin/sh
# build and run the frontend testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_frontend
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_frontend > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" sim.log; then
	exit 1
fi
exit 0
